// ==== ccuPkg.sv ====
// Configuration control unit package with widths, opcodes, config bundles and ISA layouts
`default_nettype none

package ccuPkg;

    //==========================================================================
    // Widths and sizes
    //==========================================================================
    localparam int IsaWordWidth  = 128;
    localparam int IsaDepth      = 16;
    localparam int IsaAddrWidth  = $clog2(IsaDepth);
    localparam int DramAddrWidth = 32;
    localparam int IdxWidth      = 16;   // Points or pixels
    localparam int ChnWidth      = 12;
    localparam int ActWidth      = 8;    // Activation, shift and zero point
    localparam int ScaleWidth    = 20;
    localparam int MapWidth      = 6;
    localparam int NumLayerWidth = 20;
    localparam int OpcodeWidth   = 3;

    // Opcodes sit in the low bits of a first word
    localparam logic [OpcodeWidth-1:0] OpNet  = 3'd0;
    localparam logic [OpcodeWidth-1:0] OpConv = 3'd1;
    localparam logic [OpcodeWidth-1:0] OpPool = 3'd2;

    // Words per instruction
    localparam logic [1:0] NetWords  = 2'd1;
    localparam logic [1:0] ConvWords = 2'd2;
    localparam logic [1:0] PoolWords = 2'd1;

    // Sequencer states
    localparam logic [1:0] SeqIdle   = 2'd0;
    localparam logic [1:0] SeqRun    = 2'd1;
    localparam logic [1:0] SeqFinish = 2'd2;

    //==========================================================================
    // Engine configuration bundles
    //==========================================================================
    typedef struct packed {
        logic [DramAddrWidth-1:0] datAddr;
        logic [DramAddrWidth-1:0] wgtAddr;
        logic [DramAddrWidth-1:0] ofmAddr;
        logic [IdxWidth-1:0]      nip;      // Input points
        logic [ChnWidth-1:0]      chi;
        logic [ChnWidth-1:0]      cho;
        logic [ScaleWidth-1:0]    scale;
        logic [ActWidth-1:0]      shift;
        logic [ActWidth-1:0]      zp;
        logic [1:0]               mode;
    } convCfgT;

    typedef struct packed {
        logic [DramAddrWidth-1:0] mapAddr;
        logic [IdxWidth-1:0]      nip;
        logic [ChnWidth-1:0]      chi;
        logic [MapWidth-1:0]      k;        // Kernel size
    } poolCfgT;

    // One ISA word, four views
    typedef union packed {
        struct packed {
            logic [IsaWordWidth-OpcodeWidth-NumLayerWidth-2:0] rsvd;
            logic                                              mode;
            logic [NumLayerWidth-1:0]                          numLayers;
            logic [OpcodeWidth-1:0]                            opcode;
        } net;
        struct packed {
            logic [IsaWordWidth-OpcodeWidth-3*DramAddrWidth-IdxWidth-ChnWidth-1:0] rsvd;
            logic [ChnWidth-1:0]      chi;
            logic [IdxWidth-1:0]      nip;
            logic [DramAddrWidth-1:0] ofmAddr;
            logic [DramAddrWidth-1:0] wgtAddr;
            logic [DramAddrWidth-1:0] datAddr;
            logic [OpcodeWidth-1:0]   opcode;
        } conv0;
        struct packed {
            logic [IsaWordWidth-ChnWidth-ScaleWidth-2*ActWidth-3:0] rsvd;
            logic [1:0]            mode;
            logic [ActWidth-1:0]   zp;
            logic [ActWidth-1:0]   shift;
            logic [ScaleWidth-1:0] scale;
            logic [ChnWidth-1:0]   cho;   // No opcode on a second word
        } conv1;
        struct packed {
            logic [IsaWordWidth-OpcodeWidth-DramAddrWidth-IdxWidth-ChnWidth-MapWidth-1:0] rsvd;
            logic [MapWidth-1:0]      k;
            logic [ChnWidth-1:0]      chi;
            logic [IdxWidth-1:0]      nip;
            logic [DramAddrWidth-1:0] mapAddr;
            logic [OpcodeWidth-1:0]   opcode;
        } pool;
    } isaWordT;

endpackage

`default_nettype wire

// ==== isaBuffer.sv ====
// Instruction buffer, an in-order word queue with free-entry count and registered read
`timescale 1ns/1ps
`default_nettype none

module isaBuffer import ccuPkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  clear,
    input  logic                  active,
    input  logic                  wrEn,
    input  isaWordT               wrDat,
    input  logic                  rdEn,
    output isaWordT               rdDat,
    output logic                  rdVld,
    output logic                  empty,
    output logic                  full,
    output logic                  datRdy,
    output logic [IsaAddrWidth:0] reqNum
);

    isaWordT               mem [IsaDepth];
    logic [IsaAddrWidth:0] wrPtr;
    logic [IsaAddrWidth:0] rdPtr;
    logic [IsaAddrWidth:0] count;
    logic                  wrFire;

    //==========================================================================
    // Occupancy
    //==========================================================================
    // Extra pointer bit tells full from empty
    assign count  = wrPtr - rdPtr;
    assign empty  = (count == '0);
    assign full   = (count == (IsaAddrWidth+1)'(IsaDepth));
    assign reqNum = (IsaAddrWidth+1)'(IsaDepth) - count;

    // Accept only inside a run and with room left
    assign datRdy = active & ~full;
    assign wrFire = wrEn & datRdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else if (clear) begin
            wrPtr <= '0;
            rdPtr <= '0;
        end else begin
            if (wrFire)
                wrPtr <= wrPtr + 1'b1;
            if (rdEn)
                rdPtr <= rdPtr + 1'b1;
        end
    end

    //==========================================================================
    // Storage
    //==========================================================================
    always_ff @(posedge clk) begin
        if (wrFire)
            mem[wrPtr[IsaAddrWidth-1:0]] <= wrDat;
    end

    always_ff @(posedge clk) begin
        if (rdEn)
            rdDat <= mem[rdPtr[IsaAddrWidth-1:0]];  // Word out one cycle later
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            rdVld <= 1'b0;
        else
            rdVld <= rdEn;
    end

endmodule

`default_nettype wire

// ==== isaDecoder.sv ====
// Instruction decoder that captures fields into engine configurations and holds their valids
`timescale 1ns/1ps
`default_nettype none

module isaDecoder import ccuPkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     rdVld,
    input  isaWordT                  rdDat,
    input  logic                     convCfgRdy,
    input  logic                     poolCfgRdy,
    output convCfgT                  convCfg,
    output poolCfgT                  poolCfg,
    output logic                     convCfgVld,
    output logic                     poolCfgVld,
    output logic                     busy,
    output logic                     layerDone,
    output logic [NumLayerWidth-1:0] netNumLayers,
    output logic                     netLoaded
);

    logic [1:0]             wordIdx;     // Word within current instruction
    logic [OpcodeWidth-1:0] curOp;
    logic [OpcodeWidth-1:0] wordOp;
    logic [1:0]             wordsNeeded;
    logic                   lastWord;
    logic                   instDone;
    logic                   convXfer;
    logic                   poolXfer;

    //==========================================================================
    // Word tracking
    //==========================================================================
    // First words carry the opcode, later ones reuse the latched copy
    assign wordOp = (wordIdx == 2'd0) ? rdDat.net.opcode : curOp;

    always_comb begin
        case (wordOp)
            OpNet:   wordsNeeded = NetWords;
            OpConv:  wordsNeeded = ConvWords;
            OpPool:  wordsNeeded = PoolWords;
            default: wordsNeeded = 2'd1;      // Unknown opcode, skipped
        endcase
    end

    assign lastWord = (wordIdx + 2'd1 == wordsNeeded);
    assign instDone = rdVld & lastWord;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wordIdx <= 2'd0;
            curOp   <= OpNet;
        end else if (rdVld) begin
            curOp   <= wordOp;
            wordIdx <= lastWord ? 2'd0 : wordIdx + 2'd1;
        end
    end

    //==========================================================================
    // Field capture
    //==========================================================================
    always_ff @(posedge clk) begin
        if (rdVld && wordOp == OpConv && wordIdx == 2'd0) begin
            convCfg.datAddr <= rdDat.conv0.datAddr;
            convCfg.wgtAddr <= rdDat.conv0.wgtAddr;
            convCfg.ofmAddr <= rdDat.conv0.ofmAddr;
            convCfg.nip     <= rdDat.conv0.nip;
            convCfg.chi     <= rdDat.conv0.chi;
        end else if (rdVld && wordOp == OpConv) begin
            convCfg.cho     <= rdDat.conv1.cho;
            convCfg.scale   <= rdDat.conv1.scale;
            convCfg.shift   <= rdDat.conv1.shift;
            convCfg.zp      <= rdDat.conv1.zp;
            convCfg.mode    <= rdDat.conv1.mode;
        end
        if (rdVld && wordOp == OpPool) begin
            poolCfg.mapAddr <= rdDat.pool.mapAddr;
            poolCfg.nip     <= rdDat.pool.nip;
            poolCfg.chi     <= rdDat.pool.chi;
            poolCfg.k       <= rdDat.pool.k;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            netNumLayers <= '0;
            netLoaded    <= 1'b0;
        end else if (instDone && wordOp == OpNet) begin
            netNumLayers <= rdDat.net.numLayers;
            netLoaded    <= 1'b1;
        end
    end

    //==========================================================================
    // Engine handshakes
    //==========================================================================
    assign convXfer = convCfgVld & convCfgRdy;
    assign poolXfer = poolCfgVld & poolCfgRdy;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            convCfgVld <= 1'b0;
            poolCfgVld <= 1'b0;
        end else begin
            if (convXfer)
                convCfgVld <= 1'b0;
            else if (instDone && wordOp == OpConv)
                convCfgVld <= 1'b1;
            if (poolXfer)
                poolCfgVld <= 1'b0;
            else if (instDone && wordOp == OpPool)
                poolCfgVld <= 1'b1;
        end
    end

    assign busy      = convCfgVld | poolCfgVld;  // Holds off further fetches
    assign layerDone = convXfer | poolXfer;

endmodule

`default_nettype wire

// ==== cfgSequencer.sv ====
// Run sequencer that issues buffer fetches, counts finished layers and signals network end
`timescale 1ns/1ps
`default_nettype none

module cfgSequencer import ccuPkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic                     empty,
    input  logic                     rdVld,
    input  logic                     busy,
    input  logic                     layerDone,
    input  logic                     netLoaded,
    input  logic [NumLayerWidth-1:0] netNumLayers,
    output logic                     rdEn,
    output logic                     active,
    output logic                     clear,
    output logic                     netFnh,
    output logic                     engineRst
);

    logic [1:0]               state;
    logic [1:0]               nextState;
    logic [NumLayerWidth-1:0] doneCnt;
    logic                     lastLayer;

    //==========================================================================
    // Run FSM
    //==========================================================================
    // The transfer that completes the announced layer count
    assign lastLayer = netLoaded & layerDone &
                       (doneCnt + NumLayerWidth'(1) == netNumLayers);

    always_comb begin
        nextState = state;
        case (state)
            SeqIdle: begin
                if (start)
                    nextState = SeqRun;
            end
            SeqRun: begin
                if (lastLayer)
                    nextState = SeqFinish;
            end
            SeqFinish: nextState = SeqIdle;  // Single cycle
            default:   nextState = SeqIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            state <= SeqIdle;
        else
            state <= nextState;
    end

    //==========================================================================
    // Layer count
    //==========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            doneCnt <= '0;
        else if (clear)
            doneCnt <= '0;
        else if (active && layerDone)
            doneCnt <= doneCnt + 1'b1;
    end

    //==========================================================================
    // Outputs
    //==========================================================================
    assign active = (state == SeqRun);

    // One word in flight at most, none while a config waits
    assign rdEn = active & ~empty & ~busy & ~rdVld;

    assign clear     = (state == SeqIdle && start) || state == SeqFinish;
    assign netFnh    = (state == SeqFinish);
    assign engineRst = (state == SeqIdle);   // Engines held in reset between runs

endmodule

`default_nettype wire

// ==== ccuTop.sv ====
// Configuration control unit top joining instruction buffer, sequencer and decoder
`timescale 1ns/1ps
`default_nettype none

module ccuTop import ccuPkg::*; (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  start,
    input  isaWordT               itfDat,
    input  logic                  itfDatVld,
    output logic                  datRdy,
    output logic                  itfEmpty,
    output logic [IsaAddrWidth:0] reqNum,
    output logic                  netFnh,
    // Systolic convolution array
    output convCfgT               convCfg,
    output logic                  convCfgVld,
    input  logic                  convCfgRdy,
    output logic                  syaRst,
    // Pooling engine
    output poolCfgT               poolCfg,
    output logic                  poolCfgVld,
    input  logic                  poolCfgRdy,
    output logic                  polRst
);

    logic                     rdEn;
    isaWordT                  rdDat;
    logic                     rdVld;
    logic                     empty;
    logic                     full;
    logic                     active;
    logic                     clear;
    logic                     busy;
    logic                     layerDone;
    logic [NumLayerWidth-1:0] netNumLayers;
    logic                     netLoaded;
    logic                     engineRst;

    assign itfEmpty = empty;
    assign syaRst   = engineRst;
    assign polRst   = engineRst;

    isaBuffer i_isaBuffer (
        .clk    (clk),
        .rst_n  (rst_n),
        .clear  (clear),
        .active (active),
        .wrEn   (itfDatVld),
        .wrDat  (itfDat),
        .rdEn   (rdEn),
        .rdDat  (rdDat),
        .rdVld  (rdVld),
        .empty  (empty),
        .full   (full),
        .datRdy (datRdy),
        .reqNum (reqNum)
    );

    cfgSequencer i_cfgSequencer (
        .clk          (clk),
        .rst_n        (rst_n),
        .start        (start),
        .empty        (empty),
        .rdVld        (rdVld),
        .busy         (busy),
        .layerDone    (layerDone),
        .netLoaded    (netLoaded),
        .netNumLayers (netNumLayers),
        .rdEn         (rdEn),
        .active       (active),
        .clear        (clear),
        .netFnh       (netFnh),
        .engineRst    (engineRst)
    );

    isaDecoder i_isaDecoder (
        .clk          (clk),
        .rst_n        (rst_n),
        .rdVld        (rdVld),
        .rdDat        (rdDat),
        .convCfgRdy   (convCfgRdy),
        .poolCfgRdy   (poolCfgRdy),
        .convCfg      (convCfg),
        .poolCfg      (poolCfg),
        .convCfgVld   (convCfgVld),
        .poolCfgVld   (poolCfgVld),
        .busy         (busy),
        .layerDone    (layerDone),
        .netNumLayers (netNumLayers),
        .netLoaded    (netLoaded)
    );

endmodule

`default_nettype wire

// ==== ccuTop_properties.sv ====
// Bound assertions on engine handshakes, the finish pulse and buffer write gating
`timescale 1ns/1ps
`default_nettype none

module ccuTopProperties import ccuPkg::*; (
    input logic    clk,
    input logic    rst_n,
    input convCfgT convCfg,
    input logic    convCfgVld,
    input logic    convCfgRdy,
    input poolCfgT poolCfg,
    input logic    poolCfgVld,
    input logic    poolCfgRdy,
    input logic    netFnh,
    input logic    itfDatVld,
    input logic    datRdy,
    input logic    rdEn,
    input logic    clear,
    input logic    full
);

    int                    failCount = 0;
    logic [IsaAddrWidth:0] used;   // Words held, rebuilt from the handshakes

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            used <= '0;
        else if (clear)
            used <= '0;
        else
            used <= used + (IsaAddrWidth+1)'(itfDatVld & datRdy)
                         - (IsaAddrWidth+1)'(rdEn);
    end

    convHold: assert property (@(posedge clk) disable iff (!rst_n)
        convCfgVld && !convCfgRdy |=> convCfgVld && $stable(convCfg))
        else begin
            failCount++;
            $error("convCfgVld fell or convCfg changed before ready");
        end

    poolHold: assert property (@(posedge clk) disable iff (!rst_n)
        poolCfgVld && !poolCfgRdy |=> poolCfgVld && $stable(poolCfg))
        else begin
            failCount++;
            $error("poolCfgVld fell or poolCfg changed before ready");
        end

    // Finish is a single-cycle pulse
    fnhPulse: assert property (@(posedge clk) disable iff (!rst_n) netFnh |=> !netFnh)
        else begin
            failCount++;
            $error("netFnh high for more than one cycle");
        end

    noWriteWhenFull: assert property (@(posedge clk) disable iff (!rst_n)
        used == (IsaAddrWidth+1)'(IsaDepth) |-> full && !datRdy)
        else begin
            failCount++;
            $error("datRdy high or full flag low with the buffer full");
        end

    validsAfterReset: assert property (@(posedge clk)
        $rose(rst_n) |-> !convCfgVld && !poolCfgVld)
        else begin
            failCount++;
            $error("configuration valid high right after reset");
        end

endmodule

bind ccuTop ccuTopProperties i_properties (
    .clk        (clk),
    .rst_n      (rst_n),
    .convCfg    (convCfg),
    .convCfgVld (convCfgVld),
    .convCfgRdy (convCfgRdy),
    .poolCfg    (poolCfg),
    .poolCfgVld (poolCfgVld),
    .poolCfgRdy (poolCfgRdy),
    .netFnh     (netFnh),
    .itfDatVld  (itfDatVld),
    .datRdy     (datRdy),
    .rdEn       (rdEn),
    .clear      (clear),
    .full       (full)
);

`default_nettype wire

// ==== tbCcu.sv ====
// Testbench for the configuration control unit, running two programs against engine models
`timescale 1ns/1ps
`default_nettype none

module tbCcu import ccuPkg::*; ();

    localparam int Timeout    = 400;   // Cycles per wait
    localparam int WaitConv   = 0;
    localparam int WaitFinish = 1;

    // One table row, stimulus and expected bundle together
    typedef struct packed {
        logic [OpcodeWidth-1:0]   op;
        logic [NumLayerWidth-1:0] layers;
        convCfgT                  conv;
        poolCfgT                  pool;
    } rowT;

    logic                  clk;
    logic                  rst_n;
    logic                  start;
    isaWordT               itfDat;
    logic                  itfDatVld;
    logic                  datRdy;
    logic                  itfEmpty;
    logic [IsaAddrWidth:0] reqNum;
    logic                  netFnh;
    convCfgT               convCfg;
    logic                  convCfgVld;
    logic                  convCfgRdy;
    logic                  syaRst;
    poolCfgT               poolCfg;
    logic                  poolCfgVld;
    logic                  poolCfgRdy;
    logic                  polRst;

    rowT     prog[$];
    isaWordT words[$];
    logic    expKind[$];   // 0 conv, 1 pool
    convCfgT expConv[$];
    poolCfgT expPool[$];
    int      errs[1:6];
    int      xferCount;
    int      fnhCount;
    int      nConfig;
    int      i;
    int      k;
    int      expFree;
    int      total;
    int      failedTests;
    logic    readyEn;
    int      convDelay;
    int      poolDelay;
    logic    convHeld;
    logic    poolHeld;
    convCfgT lastConv;
    convCfgT expC;
    poolCfgT lastPool;
    poolCfgT expP;

    ccuTop i_dut (.*);

    always #10 clk = ~clk;

    //==========================================================================
    // Helpers
    //==========================================================================
    task automatic report(input int t, input string msg);
        errs[t]++;
        $display("MISMATCH at %0t: %s", $time, msg);
    endtask

    task automatic timedOut(input int t, input string what);
        errs[t]++;
        $display("TIMEOUT at %0t: no %s after %0d cycles", $time, what, Timeout);
    endtask

    task automatic summary(input int t, input string name);
        if (errs[t] == 0)
            $display("Test %0d (%s): passed", t, name);
        else
            $display("Test %0d (%s): %0d errors", t, name, errs[t]);
    endtask

    function automatic logic probe(input int sel);
        return (sel == WaitConv) ? convCfgVld : netFnh;
    endfunction

    task automatic nextCycle;
        @(posedge clk);
        #2;
    endtask

    task automatic gap;
        repeat ($urandom_range(0, 2)) nextCycle();
    endtask

    task automatic pulseStart;
        start = 1'b1;
        nextCycle();
        start = 1'b0;
    endtask

    // Waits at falling edges, returns 2 ns after the next rising edge
    task automatic waitHigh(input int sel, input int t, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!probe(sel) && n < Timeout) begin
            n++;
            @(negedge clk);
        end
        if (!probe(sel))
            timedOut(t, what);
        nextCycle();
    endtask

    task automatic pushWord(input isaWordT w, input int t);
        int n;
        n = 0;
        itfDat    = w;
        itfDatVld = 1'b1;
        @(negedge clk);
        while (!datRdy && n < Timeout) begin
            n++;
            @(negedge clk);
        end
        if (!datRdy)
            timedOut(t, "buffer space for the next word");
        nextCycle();
        itfDatVld = 1'b0;
    endtask

    // N, C and P characters pick net, conv and pool rows
    task automatic buildProgram(input string ops);
        rowT          r;
        isaWordT      w;
        logic [255:0] bits;
        int           n;
        int           j;
        prog.delete();
        words.delete();
        nConfig = 0;
        for (n = 0; n < ops.len(); n++) begin
            if (ops[n] != "N")
                nConfig++;
        end
        for (n = 0; n < ops.len(); n++) begin
            for (j = 0; j < 8; j++)
                bits[j*32 +: 32] = $urandom();
            r.op     = (ops[n] == "N") ? OpNet : (ops[n] == "C") ? OpConv : OpPool;
            r.layers = NumLayerWidth'(nConfig);
            r.conv   = bits[$bits(convCfgT)-1:0];
            r.pool   = bits[255 -: $bits(poolCfgT)];
            prog.push_back(r);
        end
        for (n = 0; n < prog.size(); n++) begin
            r = prog[n];
            w = '0;
            if (r.op == OpNet) begin
                w.net.opcode    = OpNet;
                w.net.numLayers = r.layers;
                w.net.mode      = r.conv.mode[0];
                words.push_back(w);
            end else if (r.op == OpConv) begin
                w.conv0.opcode  = OpConv;
                w.conv0.datAddr = r.conv.datAddr;
                w.conv0.wgtAddr = r.conv.wgtAddr;
                w.conv0.ofmAddr = r.conv.ofmAddr;
                w.conv0.nip     = r.conv.nip;
                w.conv0.chi     = r.conv.chi;
                words.push_back(w);
                w               = '0;   // Second word, no opcode
                w.conv1.cho     = r.conv.cho;
                w.conv1.scale   = r.conv.scale;
                w.conv1.shift   = r.conv.shift;
                w.conv1.zp      = r.conv.zp;
                w.conv1.mode    = r.conv.mode;
                words.push_back(w);
                expKind.push_back(1'b0);
                expConv.push_back(r.conv);
            end else begin
                w.pool.opcode   = OpPool;
                w.pool.mapAddr  = r.pool.mapAddr;
                w.pool.nip      = r.pool.nip;
                w.pool.chi      = r.pool.chi;
                w.pool.k        = r.pool.k;
                words.push_back(w);
                expKind.push_back(1'b1);
                expPool.push_back(r.pool);
            end
        end
    endtask

    //==========================================================================
    // Engine ready models and transfer monitor
    //==========================================================================
    always @(posedge clk) begin
        #2;
        if (!readyEn || convCfgRdy) begin
            convCfgRdy = 1'b0;   // One-cycle ready, new delay
            convDelay  = $urandom_range(0, 5);
        end else if (convCfgVld) begin
            if (convDelay == 0)
                convCfgRdy = 1'b1;
            else
                convDelay--;
        end
        if (!readyEn || poolCfgRdy) begin
            poolCfgRdy = 1'b0;
            poolDelay  = $urandom_range(0, 5);
        end else if (poolCfgVld) begin
            if (poolDelay == 0)
                poolCfgRdy = 1'b1;
            else
                poolDelay--;
        end
    end

    // Falling edge sees what the next rising edge will transfer
    always @(negedge clk) begin
        if (rst_n) begin
            if (convHeld && (!convCfgVld || convCfg !== lastConv))
                report(5, "convCfg changed or dropped while waiting for ready");
            if (poolHeld && (!poolCfgVld || poolCfg !== lastPool))
                report(5, "poolCfg changed or dropped while waiting for ready");
            if (convCfgVld && convCfgRdy) begin
                xferCount++;
                if (expKind.size() == 0 || expKind[0] != 1'b0) begin
                    report(4, "convolution transfer out of table order");
                end else begin
                    void'(expKind.pop_front());
                    expC = expConv.pop_front();
                    if (convCfg !== expC)
                        report(3, $sformatf("convCfg %h, expected %h", convCfg, expC));
                end
            end
            if (poolCfgVld && poolCfgRdy) begin
                xferCount++;
                if (expKind.size() == 0 || expKind[0] != 1'b1) begin
                    report(4, "pooling transfer out of table order");
                end else begin
                    void'(expKind.pop_front());
                    expP = expPool.pop_front();
                    if (poolCfg !== expP)
                        report(4, $sformatf("poolCfg %h, expected %h", poolCfg, expP));
                end
            end
            if (netFnh)
                fnhCount++;
        end
        convHeld = convCfgVld & ~convCfgRdy;
        poolHeld = poolCfgVld & ~poolCfgRdy;
        lastConv = convCfg;
        lastPool = poolCfg;
    end

    //==========================================================================
    // Test sequence
    //==========================================================================
    initial begin
        void'($urandom(37));
        clk        = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        itfDat     = '0;
        itfDatVld  = 1'b0;
        convCfgRdy = 1'b0;
        poolCfgRdy = 1'b0;
        readyEn    = 1'b0;
        xferCount  = 0;
        fnhCount   = 0;
        for (i = 1; i <= 6; i++)
            errs[i] = 0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;

        if (datRdy || convCfgVld || poolCfgVld || netFnh)
            report(1, "handshake outputs not low after reset");
        if (!syaRst || !polRst)
            report(1, "engine resets not high while idle");
        if (reqNum != IsaDepth)
            report(1, $sformatf("reqNum %0d after reset, expected %0d", reqNum, IsaDepth));
        summary(1, "reset state");

        // Run 1, engines stalled while the buffer fills
        buildProgram("NCPCCPPCPCCPC");
        pulseStart();
        for (k = 0; k < 12; k++) begin
            pushWord(words[k], 2);
            gap();
        end
        waitHigh(WaitConv, 2, "first convolution valid");
        expFree = IsaDepth - 12 + NetWords + ConvWords;   // Net and conv words drained
        if (reqNum != expFree)
            report(2, $sformatf("reqNum %0d, expected %0d", reqNum, expFree));
        while (datRdy && k < words.size()) begin
            expFree--;
            pushWord(words[k], 2);
            k++;
            if (reqNum != expFree)
                report(2, $sformatf("reqNum %0d after write, expected %0d", reqNum, expFree));
        end
        if (datRdy || reqNum != 0 || itfEmpty)
            report(2, "buffer not reported full after filling");
        summary(2, "buffer fill");

        readyEn = 1'b1;
        while (k < words.size()) begin
            pushWord(words[k], 5);
            k++;
            gap();
        end
        waitHigh(WaitFinish, 6, "network finish of run 1");
        if (xferCount != nConfig || expKind.size() != 0)
            report(5, $sformatf("%0d transfers, expected %0d", xferCount, nConfig));
        if (!syaRst || !polRst)
            report(6, "engine resets low after run 1");

        // Run 2, three layers
        xferCount = 0;
        fnhCount  = 0;
        buildProgram("NCPC");
        pulseStart();
        if (syaRst || polRst)
            report(6, "engine resets still high during run 2");
        for (k = 0; k < words.size(); k++) begin
            pushWord(words[k], 6);
            gap();
        end
        waitHigh(WaitFinish, 6, "network finish of run 2");
        if (xferCount != 3 || expKind.size() != 0)
            report(6, $sformatf("%0d transfers before finish, expected 3", xferCount));
        repeat (4) nextCycle();
        if (fnhCount != 1)
            report(6, $sformatf("netFnh pulsed %0d times, expected once", fnhCount));
        if (!syaRst || !polRst)
            report(6, "engine resets low after run 2");
        summary(3, "convolution configuration");
        summary(4, "pooling configuration");
        summary(5, "back-pressure");
        summary(6, "finish");

        total       = i_dut.i_properties.failCount;
        failedTests = 0;
        for (i = 1; i <= 6; i++) begin
            total += errs[i];
            if (errs[i] != 0)
                failedTests++;
        end
        $display("Summary: %0d of 6 tests failed, %0d errors, %0d assertion failures",
                 failedTests, total, i_dut.i_properties.failCount);
        if (total == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
ccuPkg.sv
isaBuffer.sv
isaDecoder.sv
cfgSequencer.sv
ccuTop.sv
ccuTop_properties.sv
tbCcu.sv

// ==== Bender.yml ====
package:
  name: ccu

sources:
  - ccuPkg.sv
  - isaBuffer.sv
  - isaDecoder.sv
  - cfgSequencer.sv
  - ccuTop.sv
  - target: test
    files:
      - ccuTop_properties.sv
      - tbCcu.sv
